// ==== ncpu_ro.f ====
+incdir+design
design/ncpu_pkg.sv
design/pmux.sv
design/ro_regfile.sv
design/id_ro.sv
design/ro_stage.sv
verification/tb_ro_stage.sv

// ==== Makefile ====
# Verilator build and run for the read-operand stage testbench

TOP := tb_ro_stage
FLIST := ncpu_ro.f

.PHONY: all lint clean

all: obj_dir/$(TOP)
	./obj_dir/$(TOP)

obj_dir/$(TOP): $(FLIST) design/*.sv design/*.svh verification/*.sv
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) -o $(TOP)

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verification/tb_ro_stage.sv ====
`default_nettype none

`include "ncpu_params.svh"

module tb_ro_stage;

   import ncpu_pkg::*;

   localparam int RESET_CYCLES = 10;
   localparam int ZERO_CYCLES = 20;
   localparam int FILL_CYCLES = 40;
   localparam int READ_CYCLES = 40;
   localparam int MIX_CYCLES = 400;
   localparam int HOLD_CYCLES = 40;
   localparam int TOTAL_CYCLES = RESET_CYCLES + ZERO_CYCLES + FILL_CYCLES + READ_CYCLES
                                 + MIX_CYCLES + HOLD_CYCLES;

   logic clk;
   logic reset;
   chan_mask_t re;
   chan_addr_t raddr;
   lane_mask_t s1_we;
   lane_addr_t s1_waddr;
   lane_data_t s1_dout;
   lane_mask_t s2_we;
   lane_addr_t s2_waddr;
   lane_data_t s2_dout;
   lane_mask_t s3_we;
   lane_addr_t s3_waddr;
   lane_data_t s3_wdat;
   logic s1_load0;
   logic s2_load0;
   chan_data_t byp_dout;
   chan_mask_t raw_dep_load0;

   // Reference register file and the operands latched at the last read edge
   data_t model_rf [0:31];
   chan_data_t exp_byp;
   chan_mask_t exp_valid;
   integer seed;

   ro_stage uut (
      .clk(clk),
      .reset(reset),
      .re(re),
      .raddr(raddr),
      .s1_we(s1_we),
      .s1_waddr(s1_waddr),
      .s1_dout(s1_dout),
      .s2_we(s2_we),
      .s2_waddr(s2_waddr),
      .s2_dout(s2_dout),
      .s3_we(s3_we),
      .s3_waddr(s3_waddr),
      .s3_wdat(s3_wdat),
      .s1_load0(s1_load0),
      .s2_load0(s2_load0),
      .byp_dout(byp_dout),
      .raw_dep_load0(raw_dep_load0)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      #(TOTAL_CYCLES * 100 + 5000);
      $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] rnd();
      rnd = $random(seed);
   endfunction

   // Later assignments win so s1 beats s2 beats s3 and higher lanes beat lower ones
   function automatic data_t expect_operand(input reg_addr_t a);
      data_t v;
      v = model_rf[a];
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         if (s3_we[l] && s3_waddr[l] == a)
            v = s3_wdat[l];
      end
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         if (s2_we[l] && s2_waddr[l] == a)
            v = s2_dout[l];
      end
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         if (s1_we[l] && s1_waddr[l] == a)
            v = s1_dout[l];
      end
      return v;
   endfunction

   function automatic chan_mask_t expect_dep();
      chan_mask_t m;
      m = '0;
      for (int c = 0; c < `NCPU_CHS; c++)
      begin
         m[c] = re[c] && ((s1_we[0] && raddr[c] == s1_waddr[0] && s1_load0) ||
                          (s2_we[0] && raddr[c] == s2_waddr[0] && s2_load0));
      end
      return m;
   endfunction

   task automatic check_data(input string name, input int ch, input data_t exp, input data_t act);
      if (act !== exp)
      begin
         $display("FAILED %s ch%0d: expected %h, actual %h", name, ch, exp, act);
         $display("TB FAILED");
         $fatal(1, "operand mismatch");
      end
   endtask

   task automatic check_dep(input string name, input chan_mask_t exp, input chan_mask_t act);
      if (act !== exp)
      begin
         $display("FAILED %s raw_dep_load0: expected %b, actual %b", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "dependency mismatch");
      end
   endtask

   // Only channels that were requested at the last read edge are defined
   task automatic check_outputs(input string name);
      for (int c = 0; c < `NCPU_CHS; c++)
      begin
         if (exp_valid[c])
            check_data(name, c, exp_byp[c], byp_dout[c]);
      end
   endtask

   task automatic rand_inputs(input bit rd, input bit stages, input bit wr3,
                              input logic [31:0] amask);
      logic [31:0] r;
      r = rnd();
      re = rd ? chan_mask_t'(r) : '0;
      s1_we = stages ? lane_mask_t'(r >> 4) : '0;
      s2_we = stages ? lane_mask_t'(r >> 8) : '0;
      s3_we = wr3 ? lane_mask_t'(r >> 12) : '0;
      s1_load0 = stages & r[20];
      s2_load0 = stages & r[21];
      for (int c = 0; c < `NCPU_CHS; c++)
         raddr[c] = reg_addr_t'(rnd() & amask);
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         s1_waddr[l] = reg_addr_t'(rnd() & amask);
         s2_waddr[l] = reg_addr_t'(rnd() & amask);
         s3_waddr[l] = reg_addr_t'(rnd() & amask);
         s1_dout[l] = rnd();
         s2_dout[l] = rnd();
         s3_wdat[l] = rnd();
      end
   endtask

   // Dependency flags in the request cycle and the operands after the edge
   task automatic apply_cycle(input string name);
      #1;
      check_dep(name, expect_dep(), raw_dep_load0);
      if (|re)
      begin
         for (int c = 0; c < `NCPU_CHS; c++)
            exp_byp[c] = expect_operand(raddr[c]);
         exp_valid = re;
      end
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         if (s3_we[l])
            model_rf[s3_waddr[l]] = s3_wdat[l];
      end
      @(posedge clk);
      #5;
      check_outputs(name);
      #5;
   endtask

   initial
   begin
      seed = 32'h1bfa1f51;
      reset = 1'b1;
      re = '0;
      raddr = '0;
      s1_we = '0;
      s1_waddr = '0;
      s1_dout = '0;
      s2_we = '0;
      s2_waddr = '0;
      s2_dout = '0;
      s3_we = '0;
      s3_waddr = '0;
      s3_wdat = '0;
      s1_load0 = 1'b0;
      s2_load0 = 1'b0;
      for (int i = 0; i < 32; i++)
         model_rf[i] = '0;
      exp_byp = '0;
      exp_valid = '1;
      repeat (RESET_CYCLES) @(posedge clk);
      #10;
      reset = 1'b0;
      check_outputs("reset_zero");
      repeat (ZERO_CYCLES)
      begin
         rand_inputs(1'b1, 1'b0, 1'b0, 32'd31);
         apply_cycle("read_after_reset");
      end
      // Every fourth write cycle both lanes hit one address
      for (int i = 0; i < FILL_CYCLES; i++)
      begin
         rand_inputs(1'b0, 1'b0, 1'b1, 32'd7);
         if (i % 4 == 0)
         begin
            s3_we = '1;
            s3_waddr[1] = s3_waddr[0];
         end
         apply_cycle("s3_fill");
      end
      repeat (READ_CYCLES)
      begin
         rand_inputs(1'b1, 1'b0, 1'b0, 32'd7);
         apply_cycle("rf_readback");
      end
      repeat (MIX_CYCLES)
      begin
         rand_inputs(1'b1, 1'b1, 1'b1, 32'd7);
         apply_cycle("bypass_random");
      end
      repeat (HOLD_CYCLES)
      begin
         rand_inputs(1'b0, 1'b1, 1'b1, 32'd7);
         apply_cycle("hold_no_read");
      end
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/ro_stage.sv ====
`default_nettype none

module ro_stage
(
   input wire logic clk,
   input wire logic reset,
   // Read requests
   input ncpu_pkg::chan_mask_t re,
   input ncpu_pkg::chan_addr_t raddr,
   // Execute stage results
   input ncpu_pkg::lane_mask_t s1_we,
   input ncpu_pkg::lane_addr_t s1_waddr,
   input ncpu_pkg::lane_data_t s1_dout,
   input ncpu_pkg::lane_mask_t s2_we,
   input ncpu_pkg::lane_addr_t s2_waddr,
   input ncpu_pkg::lane_data_t s2_dout,
   // s3 also writes the register file
   input ncpu_pkg::lane_mask_t s3_we,
   input ncpu_pkg::lane_addr_t s3_waddr,
   input ncpu_pkg::lane_data_t s3_wdat,
   input wire logic s1_load0,
   input wire logic s2_load0,
   // Operands, one cycle after the request
   output ncpu_pkg::chan_data_t byp_dout,
   // Same cycle as the request
   output ncpu_pkg::chan_mask_t raw_dep_load0
);

   import ncpu_pkg::*;

   chan_data_t rf_dout;

   ro_regfile u_regfile (
      .clk(clk),
      .reset(reset),
      .we(s3_we),
      .waddr(s3_waddr),
      .wdat(s3_wdat),
      .re(re),
      .raddr(raddr),
      .rf_dout(rf_dout)
   );

   id_ro u_bypass (
      .clk(clk),
      .reset(reset),
      .s1_dout(s1_dout),
      .s2_dout(s2_dout),
      .s3_wdat(s3_wdat),
      .s1_we(s1_we),
      .s2_we(s2_we),
      .s3_we(s3_we),
      .s1_waddr(s1_waddr),
      .s2_waddr(s2_waddr),
      .s3_waddr(s3_waddr),
      .s1_load0(s1_load0),
      .s2_load0(s2_load0),
      .raddr(raddr),
      .re(re),
      .rf_din(rf_dout),
      .byp_dout(byp_dout),
      .raw_dep_load0(raw_dep_load0)
   );

endmodule

`default_nettype wire

// ==== design/id_ro.sv ====
`default_nettype none

`include "ncpu_params.svh"

module id_ro
(
   input wire logic clk,
   input wire logic reset,
   input ncpu_pkg::lane_data_t s1_dout,
   input ncpu_pkg::lane_data_t s2_dout,
   input ncpu_pkg::lane_data_t s3_wdat,
   input ncpu_pkg::lane_mask_t s1_we,
   input ncpu_pkg::lane_mask_t s2_we,
   input ncpu_pkg::lane_mask_t s3_we,
   input ncpu_pkg::lane_addr_t s1_waddr,
   input ncpu_pkg::lane_addr_t s2_waddr,
   input ncpu_pkg::lane_addr_t s3_waddr,
   input wire logic s1_load0,
   input wire logic s2_load0,
   input ncpu_pkg::chan_addr_t raddr,
   input ncpu_pkg::chan_mask_t re,
   input ncpu_pkg::chan_data_t rf_din,
   output ncpu_pkg::chan_data_t byp_dout,
   output ncpu_pkg::chan_mask_t raw_dep_load0
);

   import ncpu_pkg::*;

   logic p_ce;
   lane_data_t s1_q;
   lane_data_t s2_q;
   lane_data_t s3_q;

   // Stage registers load in step with the register file read
   assign p_ce = |re;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s1_q <= '0;
         s2_q <= '0;
         s3_q <= '0;
      end
      else if (p_ce)
      begin
         s1_q <= s1_dout;
         s2_q <= s2_dout;
         s3_q <= s3_wdat;
      end
   end

   for (genvar c = 0; c < `NCPU_CHS; c++)
   begin : gen_chan
      lane_mask_t cf_s1;
      lane_mask_t cf_s2;
      lane_mask_t cf_s3;
      lane_mask_t cf_s1_q;
      lane_mask_t cf_s2_q;
      lane_mask_t cf_s3_q;
      data_t sel_s1;
      data_t sel_s2;
      data_t sel_s3;
      logic use_s1;
      logic use_s2;
      logic use_s3;

      // Per-lane address match against each stage's write
      always_comb
      begin
         for (int l = 0; l < `NCPU_IW; l++)
         begin
            cf_s1[l] = re[c] & s1_we[l] & (raddr[c] == s1_waddr[l]);
            cf_s2[l] = re[c] & s2_we[l] & (raddr[c] == s2_waddr[l]);
            cf_s3[l] = re[c] & s3_we[l] & (raddr[c] == s3_waddr[l]);
         end
      end

      // Load in lane 0 of s1 or s2 is not ready yet
      assign raw_dep_load0[c] = (cf_s1[0] & s1_load0) | (cf_s2[0] & s2_load0);

      always_ff @(posedge clk)
      begin
         if (reset)
         begin
            cf_s1_q <= '0;
            cf_s2_q <= '0;
            cf_s3_q <= '0;
         end
         else if (p_ce)
         begin
            cf_s1_q <= cf_s1;
            cf_s2_q <= cf_s2;
            cf_s3_q <= cf_s3;
         end
      end

      pmux #(.SELW(`NCPU_IW), .T(data_t)) u_s1_pmux (
         .sel(cf_s1_q), .din(s1_q), .dout(sel_s1), .valid(use_s1)
      );
      pmux #(.SELW(`NCPU_IW), .T(data_t)) u_s2_pmux (
         .sel(cf_s2_q), .din(s2_q), .dout(sel_s2), .valid(use_s2)
      );
      pmux #(.SELW(`NCPU_IW), .T(data_t)) u_s3_pmux (
         .sel(cf_s3_q), .din(s3_q), .dout(sel_s3), .valid(use_s3)
      );

      // Youngest stage first, register file last
      assign byp_dout[c] = use_s1 ? sel_s1 :
                           use_s2 ? sel_s2 :
                           use_s3 ? sel_s3 : rf_din[c];
   end

   // Register file read data holds on cycles without a request
   a_rf_hold: assert property (
      @(posedge clk) disable iff (reset)
      !(|re) |=> $stable(rf_din)
   );

endmodule

`default_nettype wire

// ==== design/ro_regfile.sv ====
`default_nettype none

`include "ncpu_params.svh"

module ro_regfile
(
   input wire logic clk,
   input wire logic reset,
   input ncpu_pkg::lane_mask_t we,
   input ncpu_pkg::lane_addr_t waddr,
   input ncpu_pkg::lane_data_t wdat,
   input ncpu_pkg::chan_mask_t re,
   input ncpu_pkg::chan_addr_t raddr,
   output ncpu_pkg::chan_data_t rf_dout
);

   import ncpu_pkg::*;

   localparam int NREGS = 1 << `NCPU_REG_AW;

   data_t mem [0:NREGS-1];
   logic rd_ce;

   // All channels load together on any read request
   assign rd_ce = |re;

   // Write port, lanes in ascending order so the higher lane lands last
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < NREGS; i++)
         begin
            mem[i] <= '0;
         end
      end
      else
      begin
         for (int l = 0; l < `NCPU_IW; l++)
         begin
            if (we[l])
            begin
               mem[waddr[l]] <= wdat[l];
            end
         end
      end
   end

   // Read registers see the array before this edge's write
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rf_dout <= '0;
      end
      else if (rd_ce)
      begin
         for (int c = 0; c < `NCPU_CHS; c++)
         begin
            rf_dout[c] <= mem[raddr[c]];
         end
      end
   end

   // An unknown enable would corrupt an unknown entry
   a_we_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(we)
   );

endmodule

`default_nettype wire

// ==== design/pmux.sv ====
`default_nettype none

// Priority select, the highest set bit wins
module pmux
#(
   parameter int SELW = 2,
   parameter type T = logic
)
(
   input wire logic [SELW-1:0] sel,
   input T [SELW-1:0] din,
   output T dout,
   output logic valid
);

   // Any lane selected
   assign valid = |sel;

   // Higher lanes overwrite lower ones, so the youngest lane is kept
   always_comb
   begin
      dout = '0;
      for (int i = 0; i < SELW; i++)
      begin
         if (sel[i])
         begin
            dout = din[i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/ncpu_pkg.sv ====
`default_nettype none

`include "ncpu_params.svh"

package ncpu_pkg;

   // Single register value and register number
   typedef logic [`NCPU_DW-1:0] data_t;
   typedef logic [`NCPU_REG_AW-1:0] reg_addr_t;

   // One entry per issue lane
   typedef data_t [`NCPU_IW-1:0] lane_data_t;
   typedef reg_addr_t [`NCPU_IW-1:0] lane_addr_t;
   typedef logic [`NCPU_IW-1:0] lane_mask_t;

   // One entry per read channel
   // Channel c is lane c/2, odd channels carry the second operand
   typedef data_t [`NCPU_CHS-1:0] chan_data_t;
   typedef reg_addr_t [`NCPU_CHS-1:0] chan_addr_t;
   typedef logic [`NCPU_CHS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// ==== design/ncpu_params.svh ====
`ifndef NCPU_PARAMS_SVH
`define NCPU_PARAMS_SVH

// Register address width, 32 architectural registers
`define NCPU_REG_AW 5

// Data word width
`define NCPU_DW 32

// Log2 of the issue lane count
`define NCPU_P_ISSUE_WIDTH 1

// Issue lanes
`define NCPU_IW (1 << `NCPU_P_ISSUE_WIDTH)

// Read channels, two source operands per lane
`define NCPU_CHS (2 * `NCPU_IW)

`endif
